/* alu_pipe.f */
fwd_pipe_pkg.sv
hazard_forward.sv
reg_file.sv
inst_decode.sv
exec_stage.sv
alu_pipe_top.sv
alu_pipe_tb.sv

/* alu_pipe_tb.sv */
`timescale 1ns/10ps

module alu_pipe_tb;

    import fwd_pipe_pkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 4;
    localparam int DIRECTED_CYCLES = 300;
    localparam int RAND_COUNT      = 2000;
    localparam int MAX_GAP         = 3;
    // drive edge, accept edge, two stage registers, then seen at the next edge
    localparam int RETIRE_DELAY    = 4 * CLK_PERIOD;
    localparam int WATCHDOG_NS     =
        (RESET_CYCLES + DIRECTED_CYCLES + RAND_COUNT * (MAX_GAP + 1) + 20) * CLK_PERIOD;

    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] data;
        logic [63:0] due;
    } retire_t;

    logic        clk_i = 1'b0;
    logic        rst_n_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic        wb_valid_o;
    logic        wb_we_o;
    logic [4:0]  wb_waddr_o;
    logic [31:0] wb_data_o;

    logic [31:0] shadow [32];
    logic [31:0] rng_state;
    retire_t     exp_q [$];
    string       name_q [$];
    string       test_name;
    retire_t     exp_rec;
    string       exp_name;

    alu_pipe_top i_dut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_valid_o    (wb_valid_o),
        .wb_we_o       (wb_we_o),
        .wb_waddr_o    (wb_waddr_o),
        .wb_data_o     (wb_data_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    // RV32I integer semantics of one funct3 group
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            F3_ADD_SUB: return alt ? a - b : a + b;
            F3_SLL:     return a << b[4:0];
            F3_SLT:     return {31'b0, $signed(a) < $signed(b)};
            F3_SLTU:    return {31'b0, a < b};
            F3_XOR:     return a ^ b;
            F3_SRL_SRA: begin
                if (alt) begin
                    return $unsigned($signed(a) >>> b[4:0]);
                end
                return a >> b[4:0];
            end
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    // expected retire of one instruction against the shadow registers
    function automatic retire_t ref_result(input logic [31:0] ins);
        retire_t     res;
        logic [31:0] a;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        alt;
        logic        legal;
        a     = shadow[ins[19:15]];
        f3    = ins[14:12];
        f7    = ins[31:25];
        alt   = (f7 == F7_ALT);
        legal = 1'b0;
        res   = '0;
        res.waddr = ins[11:7];
        case (ins[6:0])
            OPC_LUI: begin
                legal    = 1'b1;
                res.data = {ins[31:12], 12'h000};
            end
            OPC_OP: begin
                legal    = (f7 == F7_BASE) ||
                           (alt && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA));
                res.data = alu_model(f3, alt, a, shadow[ins[24:20]]);
            end
            OPC_OP_IMM: begin
                if (f3 == F3_SLL) begin
                    legal = (f7 == F7_BASE);
                end else if (f3 == F3_SRL_SRA) begin
                    legal = (f7 == F7_BASE) || alt;
                end else begin
                    legal = 1'b1;
                end
                res.data = alu_model(f3, alt && (f3 == F3_SRL_SRA), a,
                                     {{20{ins[31]}}, ins[31:20]});
            end
            default: legal = 1'b0;
        endcase
        res.we = legal && (res.waddr != 5'd0);
        return res;
    endfunction

    // random instruction from the supported set, registers x0 to x7
    function automatic logic [31:0] rand_instr();
        logic [31:0] r;
        logic [31:0] s;
        logic [6:0]  f7;
        r  = next_rand();
        s  = next_rand();
        f7 = (r[28] && (r[27:25] == F3_ADD_SUB || r[27:25] == F3_SRL_SRA)) ? F7_ALT : F7_BASE;
        if (r[31:29] < 3'd3) begin
            return enc_r(f7, {2'b0, r[24:22]}, {2'b0, r[21:19]}, r[27:25], {2'b0, r[18:16]});
        end else if (r[31:29] < 3'd6) begin
            if (r[27:25] == F3_SLL || r[27:25] == F3_SRL_SRA) begin
                return enc_i({f7, s[24:20]}, {2'b0, r[21:19]}, r[27:25], {2'b0, r[18:16]});
            end
            return enc_i(s[31:20], {2'b0, r[21:19]}, r[27:25], {2'b0, r[18:16]});
        end
        return enc_u(s[31:12], {2'b0, r[18:16]});
    endfunction

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_error(input string msg);
        $display("Error: %s", msg);
        abort_run();
    endtask

    task automatic value_fail(input string test, input string field,
                              input logic [63:0] exp_val, input logic [63:0] act_val);
        $display("Fail %s %s: expected 0x%0h, actual 0x%0h", test, field, exp_val, act_val);
        abort_run();
    endtask

    task automatic issue(input logic [31:0] ins);
        retire_t e;
        @(posedge clk_i);
        instr_valid_i <= 1'b1;
        instr_i       <= ins;
        e     = ref_result(ins);
        e.due = $time + RETIRE_DELAY;
        exp_q.push_back(e);
        name_q.push_back(test_name);
        if (e.we) begin
            shadow[e.waddr] = e.data;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            instr_valid_i <= 1'b0;
            instr_i       <= 32'h0;
        end
    endtask

    // in-order retire checker
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            assert (!wb_valid_o && !wb_we_o) else begin
                report_error("retire port active while reset is asserted");
            end
        end else if (wb_valid_o) begin
            assert (exp_q.size() > 0) else begin
                report_error("an instruction retired that was never issued");
            end
            exp_rec  = exp_q.pop_front();
            exp_name = name_q.pop_front();
            assert ($time == exp_rec.due) else begin
                value_fail(exp_name, "retire time", exp_rec.due, $time);
            end
            assert (wb_we_o == exp_rec.we) else begin
                value_fail(exp_name, "write enable", exp_rec.we, wb_we_o);
            end
            assert (wb_waddr_o == exp_rec.waddr) else begin
                value_fail(exp_name, "write address", exp_rec.waddr, wb_waddr_o);
            end
            if (exp_rec.we) begin
                assert (wb_data_o == exp_rec.data) else begin
                    value_fail(exp_name, "write data", exp_rec.data, wb_data_o);
                end
            end
        end else begin
            assert (!wb_we_o) else begin
                report_error("write enable high while no instruction retires");
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        report_error("retire stalled, watchdog expired before the tests completed");
    end

    initial begin
        logic [31:0] r;
        int          gap;
        rst_n_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = 32'h0;
        rng_state     = 32'h235e_f08e;
        test_name     = "reset";
        for (int i = 0; i < 32; i++) begin
            shadow[i] = 32'h0;
        end
        // reset falls before the first rising clock edge
        #(CLK_PERIOD / 4);
        rst_n_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        idle(2);

        // gaps of four idle cycles keep every operand on the register file path
        test_name = "independent";
        issue(enc_u(20'hf0f0f, 5'd7));
        idle(4);
        for (int i = 1; i < 7; i++) begin
            r = next_rand();
            issue(enc_i(r[31:20], 5'd0, F3_ADD_SUB, 5'(i)));
            idle(4);
        end
        for (int f = 0; f < 8; f++) begin
            issue(enc_r(F7_BASE, 5'(((f + 4) % 7) + 1), 5'(((f + 2) % 7) + 1), 3'(f),
                        5'((f % 7) + 1)));
            idle(4);
        end
        issue(enc_r(F7_ALT, 5'd2, 5'd5, F3_ADD_SUB, 5'd6));
        idle(4);
        issue(enc_r(F7_ALT, 5'd3, 5'd7, F3_SRL_SRA, 5'd1));
        idle(4);
        for (int f = 0; f < 8; f++) begin
            r = next_rand();
            if (f == 1 || f == 5) begin
                issue(enc_i({F7_BASE, r[24:20]}, 5'd7, 3'(f), 5'(f + 1)));
            end else begin
                issue(enc_i(r[31:20], 5'((f % 7) + 1), 3'(f), 5'(((f + 3) % 7) + 1)));
            end
            idle(4);
        end
        issue(enc_i({F7_ALT, 5'd9}, 5'd7, F3_SRL_SRA, 5'd4));
        idle(4);

        // each instruction consumes the previous result straight out of execute
        test_name = "dependent_chain";
        issue(enc_i(12'h123, 5'd0, F3_ADD_SUB, 5'd1));
        for (int k = 0; k < 8; k++) begin
            r = next_rand();
            if (k % 2 == 0) begin
                issue(enc_i(r[31:20], 5'((k % 7) + 1), F3_ADD_SUB, 5'(((k + 1) % 7) + 1)));
            end else begin
                issue(enc_r(F7_ALT, 5'((k % 7) + 1), 5'd0, F3_ADD_SUB, 5'(((k + 1) % 7) + 1)));
            end
        end
        idle(4);

        test_name = "distance_2_3";
        issue(enc_i(12'd37, 5'd3, F3_ADD_SUB, 5'd3));
        issue(enc_i(12'd5, 5'd7, F3_ADD_SUB, 5'd7));
        issue(enc_r(F7_BASE, 5'd2, 5'd3, F3_ADD_SUB, 5'd4));
        idle(4);
        issue(enc_i(-12'sd9, 5'd3, F3_ADD_SUB, 5'd3));
        issue(enc_i(12'd5, 5'd7, F3_ADD_SUB, 5'd7));
        issue(enc_i(12'd1, 5'd6, F3_ADD_SUB, 5'd6));
        issue(enc_r(F7_ALT, 5'd3, 5'd2, F3_ADD_SUB, 5'd4));
        idle(4);

        // x5 pending in execute, memory and writeback at once
        test_name = "youngest_wins";
        issue(enc_i(12'd100, 5'd0, F3_ADD_SUB, 5'd5));
        issue(enc_i(12'd200, 5'd0, F3_ADD_SUB, 5'd5));
        issue(enc_i(12'd300, 5'd0, F3_ADD_SUB, 5'd5));
        issue(enc_r(F7_BASE, 5'd5, 5'd5, F3_ADD_SUB, 5'd2));
        idle(4);

        test_name = "x0_handling";
        issue(enc_i(12'd55, 5'd1, F3_ADD_SUB, 5'd0));
        issue(enc_r(F7_BASE, 5'd0, 5'd0, F3_ADD_SUB, 5'd1));
        issue(enc_u(20'h12345, 5'd0));
        issue(enc_r(F7_BASE, 5'd0, 5'd0, F3_OR, 5'd2));
        issue(enc_i(12'd0, 5'd0, F3_ADD_SUB, 5'd3));
        idle(4);

        test_name = "invalid_opcode";
        issue(32'hffff_ffff);
        issue({25'h0abcdef, 7'b0000011});
        issue(enc_r(7'b0000001, 5'd2, 5'd1, F3_ADD_SUB, 5'd3));
        issue(enc_r(F7_BASE, 5'd0, 5'd3, F3_ADD_SUB, 5'd4));
        idle(4);

        test_name = "random_mix";
        for (int n = 0; n < RAND_COUNT; n++) begin
            issue(rand_instr());
            r   = next_rand();
            gap = int'(r[31:30]);
            if (gap > 0) begin
                idle(gap);
            end
        end
        idle(1);

        for (int i = 0; i < 8 && exp_q.size() > 0; i++) begin
            @(posedge clk_i);
        end
        if (exp_q.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            report_error("issued instructions never retired");
        end
    end

endmodule

/* alu_pipe_top.sv */
`timescale 1ns/10ps

module alu_pipe_top (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    output logic        wb_valid_o,
    output logic        wb_we_o,
    output logic [4:0]  wb_waddr_o,
    output logic [31:0] wb_data_o
);

    import fwd_pipe_pkg::*;

    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic        rs1_re;
    logic        rs2_re;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        fwd_sel1;
    logic        fwd_sel2;
    logic [31:0] fwd_data1;
    logic [31:0] fwd_data2;
    id_ex_t      id_ex;
    stage_wr_t   ex_wr;
    stage_wr_t   mem_wr;
    stage_wr_t   wb_wr;

    inst_decode i_decode (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .fwd_sel1_i    (fwd_sel1),
        .fwd_sel2_i    (fwd_sel2),
        .fwd_data1_i   (fwd_data1),
        .fwd_data2_i   (fwd_data2),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_re_o      (rs1_re),
        .rs2_re_o      (rs2_re),
        .id_ex_o       (id_ex)
    );

    reg_file i_reg_file (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wb_wr_i    (wb_wr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    hazard_forward i_forward (
        .rs1_addr_i  (rs1_addr),
        .rs2_addr_i  (rs2_addr),
        .rs1_re_i    (rs1_re),
        .rs2_re_i    (rs2_re),
        .ex_wr_i     (ex_wr),
        .mem_wr_i    (mem_wr),
        .wb_wr_i     (wb_wr),
        .fwd_sel1_o  (fwd_sel1),
        .fwd_sel2_o  (fwd_sel2),
        .fwd_data1_o (fwd_data1),
        .fwd_data2_o (fwd_data2)
    );

    exec_stage i_exec (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .id_ex_i  (id_ex),
        .ex_wr_o  (ex_wr),
        .mem_wr_o (mem_wr),
        .wb_wr_o  (wb_wr)
    );

    // retire port shows the writeback record
    assign wb_valid_o = wb_wr.valid;
    assign wb_we_o    = wb_wr.we;
    assign wb_waddr_o = wb_wr.waddr;
    assign wb_data_o  = wb_wr.data;

endmodule

/* exec_stage.sv */
`timescale 1ns/10ps

module exec_stage (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  fwd_pipe_pkg::id_ex_t    id_ex_i,
    output fwd_pipe_pkg::stage_wr_t ex_wr_o,
    output fwd_pipe_pkg::stage_wr_t mem_wr_o,
    output fwd_pipe_pkg::stage_wr_t wb_wr_o
);

    import fwd_pipe_pkg::*;

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  shamt;
    logic [31:0] alu_res;
    stage_wr_t   mem_wr_q;
    stage_wr_t   wb_wr_q;

    assign op_a  = id_ex_i.op_a;
    assign op_b  = id_ex_i.op_b;
    // RV32 shifts only look at the low five bits
    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex_i.op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> shamt);
            ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = 32'b0;
        endcase
    end

    // execute result is visible to decode in the same cycle
    assign ex_wr_o.valid = id_ex_i.valid;
    assign ex_wr_o.we    = id_ex_i.we;
    assign ex_wr_o.waddr = id_ex_i.waddr;
    assign ex_wr_o.data  = alu_res;

    // memory stage only carries the result, no loads or stores
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_wr_q <= '0;
            wb_wr_q  <= '0;
        end else begin
            mem_wr_q <= ex_wr_o;
            wb_wr_q  <= mem_wr_q;
        end
    end

    assign mem_wr_o = mem_wr_q;
    assign wb_wr_o  = wb_wr_q;

endmodule

/* fwd_pipe_pkg.sv */
package fwd_pipe_pkg;

    // major opcodes handled by the pipeline
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 codes of the integer ALU group
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7, the alternate form selects SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // NOP sits at zero so a cleared stage decodes as a bubble
    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic        valid;
        alu_op_e     op;
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic [4:0]  waddr;
        logic        we;
    } id_ex_t;

    // pending register write of one stage
    typedef struct packed {
        logic        valid;
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] data;
    } stage_wr_t;

endpackage

/* hazard_forward.sv */
`timescale 1ns/10ps

module hazard_forward (
    input  logic [4:0]              rs1_addr_i,
    input  logic [4:0]              rs2_addr_i,
    input  logic                    rs1_re_i,
    input  logic                    rs2_re_i,
    input  fwd_pipe_pkg::stage_wr_t ex_wr_i,
    input  fwd_pipe_pkg::stage_wr_t mem_wr_i,
    input  fwd_pipe_pkg::stage_wr_t wb_wr_i,
    output logic                    fwd_sel1_o,
    output logic                    fwd_sel2_o,
    output logic [31:0]             fwd_data1_o,
    output logic [31:0]             fwd_data2_o
);

    logic rs1_ex_hit;
    logic rs1_mem_hit;
    logic rs1_wb_hit;
    logic rs2_ex_hit;
    logic rs2_mem_hit;
    logic rs2_wb_hit;

    // read port 1 against the three later stages
    assign rs1_ex_hit  = rs1_re_i && ex_wr_i.valid && ex_wr_i.we &&
                         (rs1_addr_i == ex_wr_i.waddr);
    assign rs1_mem_hit = rs1_re_i && mem_wr_i.valid && mem_wr_i.we &&
                         (rs1_addr_i == mem_wr_i.waddr);
    assign rs1_wb_hit  = rs1_re_i && wb_wr_i.valid && wb_wr_i.we &&
                         (rs1_addr_i == wb_wr_i.waddr);

    // read port 2
    assign rs2_ex_hit  = rs2_re_i && ex_wr_i.valid && ex_wr_i.we &&
                         (rs2_addr_i == ex_wr_i.waddr);
    assign rs2_mem_hit = rs2_re_i && mem_wr_i.valid && mem_wr_i.we &&
                         (rs2_addr_i == mem_wr_i.waddr);
    assign rs2_wb_hit  = rs2_re_i && wb_wr_i.valid && wb_wr_i.we &&
                         (rs2_addr_i == wb_wr_i.waddr);

    assign fwd_sel1_o = rs1_ex_hit | rs1_mem_hit | rs1_wb_hit;
    assign fwd_sel2_o = rs2_ex_hit | rs2_mem_hit | rs2_wb_hit;

    // youngest producer wins, execute before memory before writeback
    assign fwd_data1_o = rs1_ex_hit  ? ex_wr_i.data  :
                         rs1_mem_hit ? mem_wr_i.data :
                         rs1_wb_hit  ? wb_wr_i.data  : 32'b0;

    assign fwd_data2_o = rs2_ex_hit  ? ex_wr_i.data  :
                         rs2_mem_hit ? mem_wr_i.data :
                         rs2_wb_hit  ? wb_wr_i.data  : 32'b0;

endmodule

/* inst_decode.sv */
`timescale 1ns/10ps

module inst_decode (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 instr_valid_i,
    input  logic [31:0]          instr_i,
    input  logic [31:0]          rs1_data_i,
    input  logic [31:0]          rs2_data_i,
    input  logic                 fwd_sel1_i,
    input  logic                 fwd_sel2_i,
    input  logic [31:0]          fwd_data1_i,
    input  logic [31:0]          fwd_data2_i,
    output logic [4:0]           rs1_addr_o,
    output logic [4:0]           rs2_addr_o,
    output logic                 rs1_re_o,
    output logic                 rs2_re_o,
    output fwd_pipe_pkg::id_ex_t id_ex_o
);

    import fwd_pipe_pkg::*;

    logic [6:0]  opcode;
    logic [4:0]  rd;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic        supported;
    logic        uses_rs1;
    logic        uses_rs2;
    alu_op_e     op;
    id_ex_t      id_ex_d;

    // base operation of a funct3 code, alternate forms are patched below
    function automatic alu_op_e f3_op(input logic [2:0] f3);
        case (f3)
            F3_ADD_SUB: return ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    assign opcode     = instr_i[6:0];
    assign rd         = instr_i[11:7];
    assign funct3     = instr_i[14:12];
    assign funct7     = instr_i[31:25];
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {instr_i[31:12], 12'b0};

    always_comb begin
        op        = ALU_NOP;
        supported = 1'b0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        case (opcode)
            OPC_OP: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                if (funct7 == F7_BASE) begin
                    supported = 1'b1;
                    op        = f3_op(funct3);
                end else if (funct7 == F7_ALT && funct3 == F3_ADD_SUB) begin
                    supported = 1'b1;
                    op        = ALU_SUB;
                end else if (funct7 == F7_ALT && funct3 == F3_SRL_SRA) begin
                    supported = 1'b1;
                    op        = ALU_SRA;
                end
            end
            OPC_OP_IMM: begin
                uses_rs1 = 1'b1;
                op       = f3_op(funct3);
                // shift immediates carry a funct7 in the upper bits
                if (funct3 == F3_SLL) begin
                    supported = (funct7 == F7_BASE);
                end else if (funct3 == F3_SRL_SRA) begin
                    supported = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    if (funct7 == F7_ALT) begin
                        op = ALU_SRA;
                    end
                end else begin
                    supported = 1'b1;
                end
            end
            OPC_LUI: begin
                supported = 1'b1;
                op        = ALU_PASS_B;
            end
            default: begin
                supported = 1'b0;
            end
        endcase
        // unsupported words still retire, but as a bubble without write
        if (!supported) begin
            op       = ALU_NOP;
            uses_rs1 = 1'b0;
            uses_rs2 = 1'b0;
        end
    end

    assign rs1_re_o = instr_valid_i && uses_rs1;
    assign rs2_re_o = instr_valid_i && uses_rs2;

    // forwarded value overrides the register file
    assign rs1_val = fwd_sel1_i ? fwd_data1_i : rs1_data_i;
    assign rs2_val = fwd_sel2_i ? fwd_data2_i : rs2_data_i;

    always_comb begin
        id_ex_d.valid = instr_valid_i;
        id_ex_d.op    = instr_valid_i ? op : ALU_NOP;
        id_ex_d.op_a  = rs1_val;
        if (opcode == OPC_OP) begin
            id_ex_d.op_b = rs2_val;
        end else if (opcode == OPC_LUI) begin
            id_ex_d.op_b = imm_u;
        end else begin
            id_ex_d.op_b = imm_i;
        end
        id_ex_d.waddr = rd;
        // no stage ever advertises a write to x0
        id_ex_d.we    = instr_valid_i && supported && (rd != 5'd0);
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

/* reg_file.sv */
`timescale 1ns/10ps

module reg_file (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic [4:0]              rs1_addr_i,
    input  logic [4:0]              rs2_addr_i,
    input  fwd_pipe_pkg::stage_wr_t wb_wr_i,
    output logic [31:0]             rs1_data_o,
    output logic [31:0]             rs2_data_o
);

    // x0 has no storage
    logic [31:0] regs_q [1:31];
    logic        wr_en;

    assign wr_en = wb_wr_i.valid && wb_wr_i.we && (wb_wr_i.waddr != 5'd0);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= 32'b0;
            end
        end else if (wr_en) begin
            regs_q[wb_wr_i.waddr] <= wb_wr_i.data;
        end
    end

    // combinational reads, same-cycle writes come in through forwarding
    assign rs1_data_o = (rs1_addr_i == 5'd0) ? 32'b0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? 32'b0 : regs_q[rs2_addr_i];

endmodule
